// ==== cpu_bus_pkg.sv ====
// cpu bus side types: bus word with its data and address views, bus command
`include "cs_params.svh"

package cpu_bus_pkg;
  import cs_types_pkg::*;

  // bus word read as a control store address
  typedef struct packed {
    logic [`CS_SPARE_W-1:0] spare;  // ignored on load
    logic [`CS_ADDR_W-1:0]  addr;   // new wca value
  } cs_bus_addr_t;

  // same 16 bits, decoded by what the cycle is doing
  typedef union packed {
    logic [`CS_WORD_W-1:0] data;       // lcs write data, read data
    cs_bus_addr_t          addr_view;  // wca load
  } cs_bus_word_u;

  // command levels and strobes from the cpu side
  typedef struct packed {
    cycle_ctl_e cc;       // cycle control phase
    logic       lcs;      // load control store cycle
    logic       rwcs_wr;  // high for write, low for read
    logic [1:0] rf;       // word select within microword
    logic       wca;      // request wca load
    logic       fetch;    // sequencer fetch at upc
    logic       brk;      // break, suppresses the fetch latch
    logic       term;     // terminate, kills writes and clears wca
  } cs_cmd_t;

endpackage

// ==== cs_ctl.sv ====
// cs_ctl: control store glue, decodes command and cycle control into enables and word strobes
`timescale 1ns/1ps

module cs_ctl
  import cs_types_pkg::*, cpu_bus_pkg::*;
(
  input  logic       clk,     // only clocks the checks below
  input  logic       rst,
  input  cs_cmd_t    cmd,
  output cs_strobe_t strobes
);

  logic       data_ph;  // cycle control in data phase
  logic       addr_ph;  // cycle control in address phase
  logic       wr_stb;   // lcs write, not terminated
  logic       rd_stb;   // lcs read, not terminated
  logic [3:0] ww_dec;   // gated word decode

  // one half of a 2-to-4 decoder, enable high gives one-hot, low gives zero
  function automatic logic [3:0] dec_2to4(input logic [1:0] sel, input logic en);
    logic [3:0] y;
    y      = '0;
    y[sel] = en;
    return y;
  endfunction

  // reserved codes fall through both compares and act as idle
  assign data_ph = (cmd.cc == cc_data);
  assign addr_ph = (cmd.cc == cc_addr);

  assign wr_stb = cmd.lcs && cmd.rwcs_wr && data_ph && !cmd.term;  // term blocks the write
  assign rd_stb = cmd.lcs && !cmd.rwcs_wr && data_ph && !cmd.term;

  assign ww_dec = dec_2to4(cmd.rf, wr_stb);  // write half of the word decoder

  always_comb begin
    strobes.ecsl = cmd.fetch && !cmd.lcs && !cmd.brk;   // brk holds old microword
    strobes.ewca = cmd.wca && addr_ph && !cmd.lcs;      // load only in address phase
    strobes.wica = ww_dec[3];                           // last word written, step address
    strobes.clr  = cmd.term;                            // priority sorted out in cs_wca
    strobes.erd  = rd_stb;
    strobes.ww   = ww_dec;
    strobes.rsel = cmd.rf;                              // store reuses rf, no second decode
  end

  // sequencer fetch and an lcs cycle share the store address path
  a_fetch_lcs: assert property (
    @(posedge clk) disable iff (rst) !(cmd.fetch && cmd.lcs)
  ) else $error("cs_ctl: fetch and lcs high together");

  // at most one bank written per cycle
  a_ww_onehot: assert property (
    @(posedge clk) disable iff (rst) $onehot0(strobes.ww)
  ) else $error("cs_ctl: write strobe not one-hot");

  // bus read and bank write never meet in one cycle
  a_rd_wr: assert property (
    @(posedge clk) disable iff (rst) !(strobes.erd && (|strobes.ww))
  ) else $error("cs_ctl: read and write strobes together");

endmodule

// ==== cs_params.svh ====
// control store sizing: micro address width, microword count and bus word width
`ifndef CS_PARAMS_SVH
`define CS_PARAMS_SVH

// micro address, one address per microword
`define CS_ADDR_W 12

// microwords in the writable store, 2**CS_ADDR_W
`define CS_DEPTH 4096

// one bus word, also the width of one store bank
`define CS_WORD_W 16

// 16-bit parts per 64-bit microword, one bank each
`define CS_PARTS 4

// bits above the address in a bus word used as wca
`define CS_SPARE_W (`CS_WORD_W - `CS_ADDR_W)

`endif

// ==== cs_store.sv ====
// cs_store: four 16-bit RAM banks with fetch path into the microword latch and a bus read register
`timescale 1ns/1ps
`include "cs_params.svh"

module cs_store
  import cs_types_pkg::*, cpu_bus_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`CS_ADDR_W-1:0] upc,            // sequencer micro address
  input  logic [`CS_ADDR_W-1:0] wca_addr,       // lcs address
  input  cs_strobe_t            strobes,
  input  cs_bus_word_u          bus_in,
  output microword_t            microword,
  output logic                  mw_valid,
  output cs_bus_word_u          bus_out,
  output logic                  bus_out_valid
);

  logic [`CS_WORD_W-1:0] fetch_rd [`CS_PARTS];  // each bank at upc
  logic [`CS_WORD_W-1:0] bus_rd   [`CS_PARTS];  // each bank at wca

  // one bank per 16-bit part, bank b holds part b of every microword
  for (genvar b = 0; b < `CS_PARTS; b++) begin : g_bank
    logic [`CS_WORD_W-1:0] mem [`CS_DEPTH];

    always_ff @(posedge clk) begin
      if (strobes.ww[b])
        mem[wca_addr] <= bus_in.data;  // written at the strobe edge
    end

    assign fetch_rd[b] = mem[upc];
    assign bus_rd[b]   = mem[wca_addr];
  end

  // microword latch, one cycle after ecsl
  always_ff @(posedge clk) begin
    if (rst) begin
      microword <= '0;
      mw_valid  <= 1'b0;
    end else begin
      mw_valid <= strobes.ecsl;  // one cycle per fetch, stays low on brk
      if (strobes.ecsl) begin
        microword.part0 <= fetch_rd[0];  // word select 0 at the bottom
        microword.part1 <= fetch_rd[1];
        microword.part2 <= fetch_rd[2];
        microword.part3 <= fetch_rd[3];
      end
    end
  end

  // bus read valid flag
  always_ff @(posedge clk) begin
    if (rst)
      bus_out_valid <= 1'b0;
    else
      bus_out_valid <= strobes.erd;
  end

  // bus read data, bank picked by rsel
  always_ff @(posedge clk) begin
    if (strobes.erd)
      bus_out.data <= bus_rd[strobes.rsel];
  end

  // fetch path and lcs write path never share a cycle
  a_fetch_write: assert property (
    @(posedge clk) disable iff (rst) !(strobes.ecsl && (|strobes.ww))
  ) else $error("cs_store: microword latch during a bank write");

endmodule

// ==== cs_top.sv ====
// cs_top: writable control store, decode, write address register and RAM banks
`timescale 1ns/1ps
`include "cs_params.svh"

module cs_top
  import cs_types_pkg::*, cpu_bus_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  cs_cmd_t               cmd,            // cpu command levels
  input  cs_bus_word_u          bus_in,         // cpu data bus in
  input  logic [`CS_ADDR_W-1:0] upc,            // micro address from the sequencer
  output microword_t            microword,      // latched microword
  output logic                  mw_valid,
  output cs_bus_word_u          bus_out,        // lcs read data
  output logic                  bus_out_valid
);

  cs_strobe_t            strobes;   // decoded enables
  logic [`CS_ADDR_W-1:0] wca_addr;  // current lcs address

  cs_ctl u_ctl (
    .clk     (clk),
    .rst     (rst),
    .cmd     (cmd),
    .strobes (strobes)
  );

  cs_wca u_wca (
    .clk      (clk),
    .rst      (rst),
    .bus_in   (bus_in),
    .strobes  (strobes),
    .wca_addr (wca_addr)
  );

  cs_store u_store (
    .clk           (clk),
    .rst           (rst),
    .upc           (upc),
    .wca_addr      (wca_addr),
    .strobes       (strobes),
    .bus_in        (bus_in),
    .microword     (microword),
    .mw_valid      (mw_valid),
    .bus_out       (bus_out),
    .bus_out_valid (bus_out_valid)
  );

endmodule

// ==== cs_types_pkg.sv ====
// control store types: microword layout, cycle control codes and decoded strobes
`include "cs_params.svh"

package cs_types_pkg;

  // cycle control code, as seen during lcs
  typedef enum logic [2:0] {
    cc_idle = 3'd0,  // no activity
    cc_data = 3'd1,  // data phase of an lcs access
    cc_addr = 3'd2   // address phase, only here is a wca load taken
  } cycle_ctl_e;     // codes 3 to 7 reserved, decode as idle

  // one microword, four bank words side by side
  typedef struct packed {
    logic [`CS_WORD_W-1:0] part3;  // word select 3, top bits
    logic [`CS_WORD_W-1:0] part2;  // word select 2
    logic [`CS_WORD_W-1:0] part1;  // word select 1
    logic [`CS_WORD_W-1:0] part0;  // word select 0, lowest bits
  } microword_t;

  // enables decoded from the command, all active high
  typedef struct packed {
    logic                 ecsl;  // latch microword at upc
    logic                 ewca;  // load wca from bus
    logic                 wica;  // step wca after word 3
    logic                 clr;   // clear wca, wins over load and step
    logic                 erd;   // bus read of one bank word
    logic [`CS_PARTS-1:0] ww;    // one-hot bank write strobe
    logic [1:0]           rsel;  // bank picked for erd
  } cs_strobe_t;

endpackage

// ==== cs_wca.sv ====
// cs_wca: write control address register, loaded from the bus, stepped after word 3, cleared on term
`timescale 1ns/1ps
`include "cs_params.svh"

module cs_wca
  import cs_types_pkg::*, cpu_bus_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  cs_bus_word_u          bus_in,
  input  cs_strobe_t            strobes,
  output logic [`CS_ADDR_W-1:0] wca_addr
);

  localparam logic [`CS_ADDR_W-1:0] LAST_ADDR = `CS_ADDR_W'(`CS_DEPTH - 1);

  logic [`CS_ADDR_W-1:0] wca_next;  // value taken at the next edge

  always_comb begin
    wca_next = wca_addr;  // hold by default
    if (strobes.clr)
      wca_next = '0;                                        // term wins
    else if (strobes.ewca)
      wca_next = bus_in.addr_view.addr;                     // spare bits dropped
    else if (strobes.wica)
      wca_next = (wca_addr == LAST_ADDR) ? '0 : wca_addr + 1'b1;  // wrap at depth
  end

  always_ff @(posedge clk) begin
    if (rst)
      wca_addr <= '0;
    else
      wca_addr <= wca_next;  // same edge as the bank write
  end

  // load wants lcs low, step wants an lcs write, so they never overlap
  a_load_step: assert property (
    @(posedge clk) disable iff (rst) !(strobes.ewca && strobes.wica)
  ) else $error("cs_wca: load and increment together");

endmodule

// ==== sim.f ====
+incdir+.
cs_types_pkg.sv
cpu_bus_pkg.sv
cs_ctl.sv
cs_wca.sv
cs_store.sv
cs_top.sv
tb_cs.sv

// ==== tb_cs_tests.svh ====
// directed tests for the control store covering load, increment, fetch, break, terminate and random traffic

task automatic load_and_readback();
  int errs = err_cnt;
  load_wca(12'h123);
  write_word(2'd0, 16'hA0C0, 1'b0);
  write_word(2'd1, 16'hA1C1, 1'b0);
  write_word(2'd2, 16'hA2C2, 1'b0);
  load_wca(12'h123);                   // reload before the last word
  write_word(2'd3, 16'hA3C3, 1'b0);
  load_wca(12'h123);
  for (int w = 0; w < 4; w++)
    read_word(2'(w));
  finish_test("load and read back", errs);
endtask

task automatic auto_increment();
  int errs = err_cnt;
  load_wca(12'h2A7);
  write_word(2'd0, 16'hB0B0, 1'b0);
  write_word(2'd1, 16'hB1B1, 1'b0);
  write_word(2'd2, 16'hB2B2, 1'b0);
  write_word(2'd3, 16'hB3B3, 1'b0);    // steps wca to 2A8
  write_word(2'd0, 16'hB4B4, 1'b0);    // no reload
  load_wca(12'h2A8);
  read_word(2'd0);
  load_wca(12'h2A7);
  read_word(2'd0);                     // first word left alone
  finish_test("auto increment", errs);
endtask

task automatic fetch_latch();
  int errs = err_cnt;
  fetch_at(12'h123, 1'b0);
  finish_test("fetch", errs);
endtask

task automatic break_holds();
  int errs = err_cnt;
  fetch_at(12'h2A7, 1'b1);             // other address, must not latch
  finish_test("break", errs);
endtask

task automatic term_clears();
  int errs = err_cnt;
  load_wca(12'h123);
  write_word(2'd1, 16'hDEAD, 1'b1);    // killed write clears wca
  write_word(2'd0, 16'h5A5A, 1'b0);    // lands at address 0
  load_wca(12'h000);                   // read back from address 0 itself
  read_word(2'd0);
  load_wca(12'h123);
  read_word(2'd1);                     // still the old word
  read_word(2'd0);                     // word 0 untouched at the old address
  finish_test("terminate", errs);
endtask

task automatic random_traffic();
  int          errs = err_cnt;
  logic [15:0] r;
  logic [1:0]  sel;
  logic [11:0] addrs [8];
  for (int i = 0; i < 8; i++) begin
    take_bits(12, r);
    addrs[i] = r[11:0];
    load_wca(addrs[i]);
    for (int w = 0; w < 4; w++) begin
      take_bits(16, r);
      write_word(2'(w), r, 1'b0);
    end
  end
  for (int i = 0; i < 8; i++) begin  // overwrite one random word per address
    take_bits(2, r);
    sel = r[1:0];
    take_bits(16, r);
    load_wca(addrs[i]);
    write_word(sel, r, 1'b0);
  end
  for (int i = 0; i < 8; i++) begin
    fetch_at(addrs[i], 1'b0);
    take_bits(2, r);
    load_wca(addrs[i]);
    read_word(r[1:0]);
  end
  finish_test("random traffic", errs);
endtask

// ==== tb_cs.sv ====
// tb_cs drives the writable control store and checks it against a reference model of the banks
`timescale 1ns/1ps
`include "cs_params.svh"

module tb_cs
  import cs_types_pkg::*, cpu_bus_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 2000;  // well above the length of all tests together

  logic                  clk = 1'b0;
  logic                  rst;
  cs_cmd_t               cmd;
  cs_bus_word_u          bus_in;
  logic [`CS_ADDR_W-1:0] upc;
  microword_t            microword;
  logic                  mw_valid;
  cs_bus_word_u          bus_out;
  logic                  bus_out_valid;

  logic [`CS_WORD_W-1:0] ref_mem [`CS_PARTS][`CS_DEPTH];  // model of the four banks
  logic [`CS_ADDR_W-1:0] model_wca = '0;                  // expected wca after each command
  microword_t            last_mw = '0;                    // expected latch contents
  logic [15:0]           lfsr_state = 16'd21;
  int                    cycle_cnt = 0;
  int                    err_cnt = 0;
  int                    check_cnt = 0;
  int                    test_cnt = 0;

  always #2 clk = ~clk;  // 4 ns period

  cs_top dut0 (
    .clk           (clk),
    .rst           (rst),
    .cmd           (cmd),
    .bus_in        (bus_in),
    .upc           (upc),
    .microword     (microword),
    .mw_valid      (mw_valid),
    .bus_out       (bus_out),
    .bus_out_valid (bus_out_valid)
  );

  // run limit counting every rising edge
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $finish;
    end
  end

  // galois lfsr with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [15:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val[i]     = lfsr_state[0];             // one step per bit
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic check_microword(input microword_t got, input microword_t exp,
                                 input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s, microword %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bus_word(input cs_bus_word_u got, input cs_bus_word_u exp,
                                input string what);
    check_cnt++;
    if (got.data !== exp.data) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s, bus word %h, expected %h", $time, what, got.data,
               exp.data);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // inputs change 1 ns after the edge when outputs have settled
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic load_wca(input logic [`CS_ADDR_W-1:0] addr);
    cmd                     = '0;
    cmd.cc                  = cc_addr;   // load only honoured in address phase
    cmd.wca                 = 1'b1;
    bus_in.addr_view.addr   = addr;
    bus_in.addr_view.spare  = 4'hA;      // junk above the address that the load ignores
    next_cycle();
    cmd       = '0;
    model_wca = addr;
  endtask

  task automatic write_word(input logic [1:0] rf, input logic [15:0] data, input logic term);
    cmd         = '0;
    cmd.cc      = cc_data;
    cmd.lcs     = 1'b1;
    cmd.rwcs_wr = 1'b1;
    cmd.rf      = rf;
    cmd.term    = term;
    bus_in.data = data;
    next_cycle();
    cmd = '0;
    if (term) begin
      model_wca = '0;                        // nothing stored and address cleared
    end else begin
      ref_mem[rf][model_wca] = data;
      if (rf == 2'd3)
        model_wca = model_wca + 1'b1;        // wraps at depth by width
    end
  endtask

  task automatic read_word(input logic [1:0] rf);
    cs_bus_word_u exp;
    exp.data = ref_mem[rf][model_wca];
    cmd      = '0;
    cmd.cc   = cc_data;
    cmd.lcs  = 1'b1;
    cmd.rf   = rf;                           // rwcs_wr low for read
    next_cycle();
    cmd = '0;
    check_flag(bus_out_valid, 1'b1, "bus_out_valid after read");
    check_bus_word(bus_out, exp, "lcs read data");
  endtask

  task automatic fetch_at(input logic [`CS_ADDR_W-1:0] addr, input logic brk);
    microword_t exp;
    if (brk)
      exp = last_mw;                         // latch must hold
    else
      exp = {ref_mem[3][addr], ref_mem[2][addr], ref_mem[1][addr], ref_mem[0][addr]};
    upc       = addr;
    cmd       = '0;
    cmd.fetch = 1'b1;
    cmd.brk   = brk;
    next_cycle();
    cmd = '0;
    check_flag(mw_valid, !brk, "mw_valid after fetch");
    check_microword(microword, exp, "latched microword");
    last_mw = exp;
    next_cycle();
    check_flag(mw_valid, 1'b0, "mw_valid second cycle");  // one cycle per fetch
  endtask

  task automatic finish_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before)
      $display("test %s: done, no errors", name);
    else
      $display("test %s: done, %0d errors", name, err_cnt - errs_before);
  endtask

  `include "tb_cs_tests.svh"

  initial begin
    rst    = 1'b1;
    cmd    = '0;
    bus_in = '0;
    upc    = '0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    check_flag(mw_valid, 1'b0, "mw_valid after reset");
    check_flag(bus_out_valid, 1'b0, "bus_out_valid after reset");
    check_microword(microword, '0, "microword after reset");
    load_and_readback();
    auto_increment();
    fetch_latch();
    break_holds();
    term_clears();
    random_traffic();
    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule
